// File: decode_sub.f
hdl/rv_decode_pkg.sv
hdl/instr_decoder.sv
hdl/register_file.sv
hdl/operand_forward.sv
hdl/branch_compare.sv
hdl/address_gen.sv
hdl/decode_stage.sv
hdl/decode_top.sv
bench/decode_sva.sv
bench/decode_tb.sv

// File: Bender.yml
package:
  name: decode_sub

sources:
  - hdl/rv_decode_pkg.sv
  - hdl/instr_decoder.sv
  - hdl/register_file.sv
  - hdl/operand_forward.sv
  - hdl/branch_compare.sv
  - hdl/address_gen.sv
  - hdl/decode_stage.sv
  - hdl/decode_top.sv
  - target: test
    files:
      - bench/decode_sva.sv
      - bench/decode_tb.sv

// File: bench/decode_tb.sv
`timescale 1ns/1ns

module decode_tb import rv_decode_pkg::*; ();

    localparam int max_cycles = 400; // Well above the roughly 50 cycles of reset and tests.

    logic           clk;
    logic           rst;
    fetch_type      fetch;
    wb_type         wb;
    logic           flush;
    decode_out_type q;
    mem_req_type    dmem;
    logic [31:0]    lfsr_state = 32'h4fe01610;
    int             cycles = 0;

    decode_top dut_i (
        .clk(clk), .rst(rst), .fetch(fetch), .wb(wb), .flush(flush), .q(q), .dmem(dmem)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("Timeout after %0d cycles, the tests did not finish", cycles);
            $display("Simulation failed");
            $fatal(1);
        end
    end

    // Taps 32, 22, 2 and 1.
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            val = {val[30:0], lfsr_state[0]};
        end
        return val;
    endfunction

    function automatic logic [31:0] itype_word(input logic [11:0] imm, input logic [4:0] rs1,
                                               input logic [2:0] f3, input logic [4:0] rd,
                                               input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] stype_word(input logic [11:0] imm, input logic [4:0] rs2,
                                               input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], opcode_store};
    endfunction

    function automatic logic [31:0] btype_word(input logic [12:0] imm, input logic [4:0] rs2,
                                               input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opcode_branch};
    endfunction

    function automatic logic [31:0] jtype_word(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opcode_jal};
    endfunction

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
        fetch.valid = 1'b0;
        wb = '0;
        flush = 1'b0;
    endtask

    task automatic present(input logic [31:0] pc, input logic [31:0] instr);
        fetch.pc = pc;
        fetch.instr = instr;
        fetch.valid = 1'b1;
        #4; // Lets the combinational request settle before dmem is sampled.
    endtask

    task automatic write_reg(input logic [4:0] addr, input logic [31:0] data);
        wb.wren = 1'b1;
        wb.waddr = addr;
        wb.wdata = data;
        next_cycle();
    endtask

    task automatic after_reset();
        compare("reset valid", 1'b0, q.valid);
        compare("reset wren", 1'b0, q.wren);
        compare("reset jump", 1'b0, q.jump);
        compare("reset exception", 1'b0, q.exception);
        fetch.instr = stype_word(12'h010, 5'd2, 5'd1, 3'b010);
        fetch.valid = 1'b0;
        #4;
        compare("idle mem_valid", 1'b0, dmem.mem_valid);
        next_cycle();
        compare("idle valid", 1'b0, q.valid);
    endtask

    task automatic immediate_ops();
        logic [31:0] val;
        logic [11:0] imm12;
        logic [19:0] imm20;
        val = rand_bits(32);
        imm12 = 12'(rand_bits(12));
        write_reg(5'd5, val);
        present(32'h100, itype_word(imm12, 5'd5, 3'b000, 5'd7, opcode_opimm));
        next_cycle();
        compare("addi imm", {{20{imm12[11]}}, imm12}, q.imm);
        compare("addi waddr", 5'd7, q.waddr);
        compare("addi alu_op", alu_add, q.alu_op);
        compare("addi wren", 1'b1, q.wren);
        compare("addi rdata1", val, q.rdata1);
        imm20 = 20'(rand_bits(20));
        present(32'h104, {imm20, 5'd8, opcode_lui});
        next_cycle();
        compare("lui imm", {imm20, 12'h000}, q.imm);
        compare("lui waddr", 5'd8, q.waddr);
        compare("lui select", 1'b1, q.lui);
        compare("lui wren", 1'b1, q.wren);
        imm20 = 20'(rand_bits(20));
        present(32'h108, {imm20, 5'd9, opcode_auipc});
        next_cycle();
        compare("auipc imm", {imm20, 12'h000}, q.imm);
        compare("auipc waddr", 5'd9, q.waddr);
        compare("auipc select", 1'b1, q.auipc);
        compare("auipc wren", 1'b1, q.wren);
    endtask

    task automatic forwarding();
        logic [31:0] val;
        val = rand_bits(32);
        wb.wren = 1'b1;
        wb.waddr = 5'd9;
        wb.wdata = val;
        present(32'h200, itype_word(12'h000, 5'd9, 3'b000, 5'd1, opcode_opimm));
        next_cycle();
        compare("forward same cycle", val, q.rdata1);
        present(32'h204, itype_word(12'h000, 5'd9, 3'b000, 5'd2, opcode_opimm));
        next_cycle();
        compare("forward stored", val, q.rdata1);
        wb.wren = 1'b1; // A write to x0 must not be bypassed either.
        wb.waddr = 5'd0;
        wb.wdata = val;
        present(32'h208, itype_word(12'h000, 5'd0, 3'b000, 5'd3, opcode_opimm));
        next_cycle();
        compare("forward x0", 32'h0, q.rdata1);
    endtask

    task automatic branches_and_jumps();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] pc;
        logic [12:0] boff;
        logic [20:0] joff;
        logic [11:0] jimm;
        logic [2:0]  f3;
        logic        expect_jump;
        for (int pair = 0; pair < 2; pair++) begin
            a = rand_bits(32);
            b = (pair == 0) ? a : rand_bits(32);
            write_reg(5'd10, a);
            write_reg(5'd11, b);
            for (int k = 0; k < 4; k++) begin
                case (k)
                    0: begin
                        f3 = 3'b000;
                        expect_jump = a == b;
                    end
                    1: begin
                        f3 = 3'b001;
                        expect_jump = a != b;
                    end
                    2: begin
                        f3 = 3'b100;
                        expect_jump = $signed(a) < $signed(b);
                    end
                    default: begin
                        f3 = 3'b110;
                        expect_jump = a < b;
                    end
                endcase
                boff = {11'(rand_bits(11)), 2'b00};
                pc = {16'h0000, 14'(rand_bits(14)), 2'b00};
                present(pc, btype_word(boff, 5'd11, 5'd10, f3));
                next_cycle();
                compare("branch jump", expect_jump, q.jump);
                compare("branch target", pc + {{19{boff[12]}}, boff}, q.address);
                compare("branch wren", 1'b0, q.wren);
            end
        end
        joff = {19'(rand_bits(19)), 2'b00};
        pc = 32'h0000_8000;
        present(pc, jtype_word(joff, 5'd1));
        next_cycle();
        compare("jal jump", 1'b1, q.jump);
        compare("jal target", pc + {{11{joff[20]}}, joff}, q.address);
        compare("jal wren", 1'b1, q.wren);
        a = {30'(rand_bits(30)), 2'b00};
        jimm = {10'(rand_bits(10)), 2'b01}; // Bit zero of the sum is dropped.
        write_reg(5'd12, a);
        present(pc, itype_word(jimm, 5'd12, 3'b000, 5'd1, opcode_jalr));
        next_cycle();
        compare("jalr jump", 1'b1, q.jump);
        compare("jalr target", (a + {{20{jimm[11]}}, jimm}) & 32'hffff_fffe, q.address);
        compare("jalr exception", 1'b0, q.exception);
    endtask

    task automatic store_access(input string name, input logic [31:0] base,
                                input logic [2:0] f3, input logic [1:0] lo,
                                input logic [3:0] strb, input logic [31:0] wdata);
        logic [11:0] imm;
        logic [31:0] addr;
        imm = {10'(rand_bits(10)), lo};
        addr = base + {{20{imm[11]}}, imm};
        present(32'h300, stype_word(imm, 5'd14, 5'd13, f3));
        compare({name, " mem_valid"}, 1'b1, dmem.mem_valid);
        compare({name, " addr"}, addr, dmem.mem_addr);
        compare({name, " wdata"}, wdata, dmem.mem_wdata);
        compare({name, " wstrb"}, strb, dmem.mem_wstrb);
        next_cycle();
    endtask

    task automatic loads_and_stores();
        logic [31:0] base;
        logic [31:0] data;
        logic [31:0] addr;
        logic [11:0] imm;
        base = {30'(rand_bits(30)), 2'b00};
        data = rand_bits(32);
        write_reg(5'd13, base);
        write_reg(5'd14, data);
        store_access("sw", base, 3'b010, 2'b00, 4'b1111, data);
        store_access("sh", base, 3'b001, 2'b10, 4'b1100, {2{data[15:0]}});
        store_access("sb", base, 3'b000, 2'b11, 4'b1000, {4{data[7:0]}});
        imm = {10'(rand_bits(10)), 2'b00};
        addr = base + {{20{imm[11]}}, imm};
        present(32'h310, itype_word(imm, 5'd13, 3'b010, 5'd4, opcode_load));
        compare("lw mem_valid", 1'b1, dmem.mem_valid);
        compare("lw addr", addr, dmem.mem_addr);
        compare("lw wstrb", 4'b0000, dmem.mem_wstrb);
        next_cycle();
        compare("lw load", 1'b1, q.load);
        compare("lw wren", 1'b1, q.wren);
        imm = {10'(rand_bits(10)), 2'b10};
        addr = base + {{20{imm[11]}}, imm};
        present(32'h314, itype_word(imm, 5'd13, 3'b010, 5'd4, opcode_load));
        compare("misaligned lw mem_valid", 1'b0, dmem.mem_valid);
        next_cycle();
        compare("misaligned lw exception", 1'b1, q.exception);
        compare("misaligned lw cause", except_load_misaligned, q.ecause);
        compare("misaligned lw etval", addr, q.etval);
        compare("misaligned lw load", 1'b0, q.load);
        compare("misaligned lw wren", 1'b0, q.wren);
    endtask

    task automatic expect_trap(input string name, input logic [31:0] instr,
                               input logic [3:0] cause);
        present(32'h400, instr);
        next_cycle();
        compare({name, " exception"}, 1'b1, q.exception);
        compare({name, " cause"}, cause, q.ecause);
        compare({name, " etval"}, instr, q.etval);
        compare({name, " wren"}, 1'b0, q.wren);
    endtask

    task automatic exceptions_and_flush();
        logic [31:0] bad;
        bad = {25'(rand_bits(25)), 7'b1111111}; // No RV32I opcode ends in all ones.
        expect_trap("illegal", bad, except_illegal_instruction);
        expect_trap("ecall", 32'h00000073, except_env_call_mach);
        expect_trap("ebreak", 32'h00100073, except_breakpoint);
        flush = 1'b1;
        present(32'h404, bad);
        next_cycle();
        compare("flush valid", 1'b0, q.valid);
        compare("flush exception", 1'b0, q.exception);
        flush = 1'b1;
        present(32'h408, itype_word(12'h000, 5'd13, 3'b010, 5'd4, opcode_load));
        compare("flush mem_valid", 1'b0, dmem.mem_valid);
        next_cycle();
        compare("flush wren", 1'b0, q.wren);
        compare("flush load", 1'b0, q.load);
    endtask

    initial begin
        rst = 1'b0;
        fetch = '0;
        wb = '0;
        flush = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b1;
        after_reset();
        immediate_ops();
        forwarding();
        branches_and_jumps();
        loads_and_stores();
        exceptions_and_flush();
        $display("Simulation passed");
        $finish;
    end

endmodule

// File: bench/decode_sva.sv
`timescale 1ns/1ns

module decode_sva import rv_decode_pkg::*; (
    input logic            clk,
    input logic            rst,
    input fetch_type       fetch,
    input logic            flush,
    input decoder_out_type dec,
    input agu_out_type     agu_out,
    input decode_out_type  q,
    input mem_req_type     dmem
);

    valid_after_reset: assert property (@(posedge clk) $rose(rst) |-> !q.valid)
        else $error("q.valid is set in the first cycle after reset");

    mem_valid_access: assert property (@(posedge clk) disable iff (!rst)
        dmem.mem_valid |-> fetch.valid && !flush && (dec.load || dec.store) &&
                           dec.legal && !agu_out.exception)
        else $error("Memory request without a clean load or store");

    load_no_strobe: assert property (@(posedge clk) disable iff (!rst)
        (dmem.mem_valid && dec.load) |-> dmem.mem_wstrb == 4'h0)
        else $error("Load request drives write strobes");

    trap_no_write: assert property (@(posedge clk) disable iff (!rst)
        q.exception |-> !q.wren)
        else $error("Registered exception still writes a register");

endmodule

bind decode_stage decode_sva sva_i (
    .clk(clk), .rst(rst), .fetch(fetch), .flush(flush), .dec(dec), .agu_out(agu_out),
    .q(q), .dmem(dmem)
);

// File: hdl/decode_top.sv
`timescale 1ns/1ns

module decode_top import rv_decode_pkg::*; (
    input  logic           clk,
    input  logic           rst,
    input  fetch_type      fetch,
    input  wb_type         wb,
    input  logic           flush,
    output decode_out_type q,
    output mem_req_type    dmem
);

    decoder_out_type dec;
    logic [31:0]     instr;
    logic [4:0]      raddr1;
    logic [4:0]      raddr2;
    logic            rden1;
    logic            rden2;
    logic [31:0]     rf_data1;
    logic [31:0]     rf_data2;
    logic [31:0]     data1;
    logic [31:0]     data2;
    bcu_op_type      bcu_op;
    logic [31:0]     bcu_rdata1;
    logic [31:0]     bcu_rdata2;
    logic            taken;
    agu_in_type      agu_in;
    agu_out_type     agu_out;

    decode_stage stage_i (
        .clk(clk), .rst(rst), .fetch(fetch), .flush(flush),
        .dec(dec), .instr(instr),
        .raddr1(raddr1), .raddr2(raddr2), .rden1(rden1), .rden2(rden2),
        .data1(data1), .data2(data2),
        .bcu_op(bcu_op), .bcu_rdata1(bcu_rdata1), .bcu_rdata2(bcu_rdata2), .taken(taken),
        .agu_in(agu_in), .agu_out(agu_out),
        .dmem(dmem), .q(q)
    );

    instr_decoder decoder_i (.instr(instr), .dec(dec));

    register_file regfile_i (
        .clk(clk), .wb(wb),
        .raddr1(raddr1), .raddr2(raddr2), .rdata1(rf_data1), .rdata2(rf_data2)
    );

    operand_forward forward_i (
        .raddr1(raddr1), .raddr2(raddr2), .rden1(rden1), .rden2(rden2),
        .rf_data1(rf_data1), .rf_data2(rf_data2), .wb(wb),
        .data1(data1), .data2(data2)
    );

    branch_compare bcu_i (
        .rdata1(bcu_rdata1), .rdata2(bcu_rdata2), .bcu_op(bcu_op), .taken(taken)
    );

    address_gen agu_i (.agu_in(agu_in), .agu_out(agu_out));

endmodule

// File: hdl/decode_stage.sv
`timescale 1ns/1ns

module decode_stage import rv_decode_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  fetch_type       fetch,
    input  logic            flush,
    input  decoder_out_type dec,
    output logic [31:0]     instr,
    output logic [4:0]      raddr1,
    output logic [4:0]      raddr2,
    output logic            rden1,
    output logic            rden2,
    input  logic [31:0]     data1,
    input  logic [31:0]     data2,
    output bcu_op_type      bcu_op,
    output logic [31:0]     bcu_rdata1,
    output logic [31:0]     bcu_rdata2,
    input  logic            taken,
    output agu_in_type      agu_in,
    input  agu_out_type     agu_out,
    output mem_req_type     dmem,
    output decode_out_type  q
);

    decode_out_type v;
    logic           kill;
    logic           addr_exc;

    assign instr = fetch.instr;
    assign raddr1 = fetch.instr[19:15];
    assign raddr2 = fetch.instr[24:20];
    assign rden1 = dec.rden1;
    assign rden2 = dec.rden2;
    assign bcu_op = dec.bcu_op;
    assign bcu_rdata1 = data1;
    assign bcu_rdata2 = data2;

    assign kill = flush | ~fetch.valid;

    // Misaligned addresses only matter for accesses and jumps that really happen.
    assign addr_exc = agu_out.exception &
                      (dec.load | dec.store | dec.jal | dec.jalr | (dec.branch & taken));

    always_comb begin
        agu_in.rdata1 = data1;
        agu_in.imm = dec.imm;
        agu_in.pc = fetch.pc;
        agu_in.jal = dec.jal;
        agu_in.jalr = dec.jalr;
        agu_in.branch = dec.branch;
        agu_in.load = dec.load;
        agu_in.store = dec.store;
        agu_in.lsu_op = dec.lsu_op;
    end

    always_comb begin
        v = '0;
        v.pc = fetch.pc;
        v.npc = fetch.pc + 32'd4;
        v.imm = dec.imm;
        v.waddr = fetch.instr[11:7];
        v.raddr1 = raddr1;
        v.raddr2 = raddr2;
        v.rdata1 = data1;
        v.rdata2 = data2;
        v.wren = dec.wren;
        v.auipc = dec.auipc;
        v.lui = dec.lui;
        v.jal = dec.jal;
        v.jalr = dec.jalr;
        v.branch = dec.branch;
        v.load = dec.load;
        v.store = dec.store;
        v.ecall = dec.ecall;
        v.ebreak = dec.ebreak;
        v.fence = dec.fence;
        v.jump = dec.jal | dec.jalr | (dec.branch & taken);
        v.address = agu_out.address;
        v.byteenable = agu_out.byteenable;
        v.alu_op = dec.alu_op;
        v.bcu_op = dec.bcu_op;
        v.lsu_op = dec.lsu_op;
        v.valid = 1'b1;

        if (!dec.legal) begin
            v.exception = 1'b1;
            v.ecause = except_illegal_instruction;
            v.etval = fetch.instr;
        end else if (dec.ebreak) begin
            v.exception = 1'b1;
            v.ecause = except_breakpoint;
            v.etval = fetch.instr;
        end else if (dec.ecall) begin
            v.exception = 1'b1;
            v.ecause = except_env_call_mach;
            v.etval = fetch.instr;
        end else if (addr_exc) begin
            v.exception = 1'b1;
            v.ecause = agu_out.ecause;
            v.etval = agu_out.address;
        end

        if (v.exception) begin
            v.wren = 1'b0; // A trapping instruction retires nothing.
            v.load = 1'b0;
            v.store = 1'b0;
            v.jump = 1'b0;
        end

        if (kill) begin
            v.wren = 1'b0;
            v.auipc = 1'b0;
            v.lui = 1'b0;
            v.jal = 1'b0;
            v.jalr = 1'b0;
            v.branch = 1'b0;
            v.load = 1'b0;
            v.store = 1'b0;
            v.ecall = 1'b0;
            v.ebreak = 1'b0;
            v.fence = 1'b0;
            v.jump = 1'b0;
            v.valid = 1'b0;
            v.exception = 1'b0;
        end
    end

    assign dmem.mem_valid = v.load | v.store;
    assign dmem.mem_addr = v.address;
    assign dmem.mem_wdata = store_data(v.rdata2, v.lsu_op);
    assign dmem.mem_wstrb = v.store ? v.byteenable : 4'h0; // Loads never drive strobes.

    always_ff @(posedge clk) begin
        if (!rst) begin
            q <= init_decode_out;
        end else begin
            q <= v;
        end
    end

endmodule

// File: hdl/address_gen.sv
`timescale 1ns/1ns

module address_gen import rv_decode_pkg::*; (
    input  agu_in_type  agu_in,
    output agu_out_type agu_out
);

    logic [31:0] base;
    logic [31:0] sum;
    logic [31:0] addr;
    logic        mem_access;

    assign mem_access = agu_in.load | agu_in.store;
    assign base = (agu_in.jalr | mem_access) ? agu_in.rdata1 : agu_in.pc;
    assign sum = base + agu_in.imm;
    assign addr = agu_in.jalr ? {sum[31:1], 1'b0} : sum;

    always_comb begin
        agu_out = '0;
        agu_out.address = addr;
        if (mem_access) begin
            if (agu_in.lsu_op.lsu_byte) begin
                agu_out.byteenable = 4'b0001 << addr[1:0];
            end else if (agu_in.lsu_op.lsu_half) begin
                agu_out.byteenable = addr[1] ? 4'b1100 : 4'b0011;
            end else begin
                agu_out.byteenable = 4'b1111;
            end
            agu_out.exception = (agu_in.lsu_op.lsu_half & addr[0]) |
                                (agu_in.lsu_op.lsu_word & (addr[1:0] != 2'b00));
            agu_out.ecause = agu_in.load ? except_load_misaligned : except_store_misaligned;
        end else if (agu_in.jal | agu_in.jalr | agu_in.branch) begin
            agu_out.exception = addr[1:0] != 2'b00; // Targets must be word aligned.
            agu_out.ecause = except_instr_misaligned;
        end
    end

endmodule

// File: hdl/branch_compare.sv
`timescale 1ns/1ns

module branch_compare import rv_decode_pkg::*; (
    input  logic [31:0] rdata1,
    input  logic [31:0] rdata2,
    input  bcu_op_type  bcu_op,
    output logic        taken
);

    logic equal;
    logic less;
    logic less_u;

    assign equal  = rdata1 == rdata2;
    assign less   = $signed(rdata1) < $signed(rdata2);
    assign less_u = rdata1 < rdata2;

    always_comb begin
        case (bcu_op)
            bcu_beq:  taken = equal;
            bcu_bne:  taken = ~equal;
            bcu_blt:  taken = less;
            bcu_bge:  taken = ~less;
            bcu_bltu: taken = less_u;
            bcu_bgeu: taken = ~less_u;
            default:  taken = 1'b0;
        endcase
    end

endmodule

// File: hdl/operand_forward.sv
`timescale 1ns/1ns

module operand_forward import rv_decode_pkg::*; (
    input  logic [4:0]  raddr1,
    input  logic [4:0]  raddr2,
    input  logic        rden1,
    input  logic        rden2,
    input  logic [31:0] rf_data1,
    input  logic [31:0] rf_data2,
    input  wb_type      wb,
    output logic [31:0] data1,
    output logic [31:0] data2
);

    logic hit1;
    logic hit2;

    assign hit1 = rden1 && wb.wren && wb.waddr != 5'd0 && wb.waddr == raddr1;
    assign hit2 = rden2 && wb.wren && wb.waddr != 5'd0 && wb.waddr == raddr2;

    assign data1 = hit1 ? wb.wdata : rf_data1; // Bypass the write landing this edge.
    assign data2 = hit2 ? wb.wdata : rf_data2;

endmodule

// File: hdl/register_file.sv
`timescale 1ns/1ns

module register_file import rv_decode_pkg::*; (
    input  logic        clk,
    input  wb_type      wb,
    input  logic [4:0]  raddr1,
    input  logic [4:0]  raddr2,
    output logic [31:0] rdata1,
    output logic [31:0] rdata2
);

    logic [31:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (wb.wren && wb.waddr != 5'd0) begin
            regs[wb.waddr] <= wb.wdata;
        end
    end

    assign rdata1 = (raddr1 == 5'd0) ? 32'd0 : regs[raddr1]; // x0 is hardwired.
    assign rdata2 = (raddr2 == 5'd0) ? 32'd0 : regs[raddr2];

endmodule

// File: hdl/instr_decoder.sv
`timescale 1ns/1ns

module instr_decoder import rv_decode_pkg::*; (
    input  logic [31:0]     instr,
    output decoder_out_type dec
);

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;
    lsu_op_type  lsu;

    function automatic alu_op_type alu_sel(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? alu_sub : alu_add;
            3'b001:  return alu_sll;
            3'b010:  return alu_slt;
            3'b011:  return alu_sltu;
            3'b100:  return alu_xor;
            3'b101:  return alt ? alu_sra : alu_srl;
            3'b110:  return alu_or;
            default: return alu_and;
        endcase
    endfunction

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    assign lsu.lsu_byte     = funct3[1:0] == 2'b00;
    assign lsu.lsu_half     = funct3[1:0] == 2'b01;
    assign lsu.lsu_word     = funct3[1:0] == 2'b10;
    assign lsu.lsu_unsigned = funct3[2];

    always_comb begin
        dec = '0;
        dec.alu_op = alu_add;
        dec.bcu_op = bcu_beq;
        dec.lsu_op = lsu;
        case (opcode)
            opcode_lui: begin
                dec.imm = imm_u;
                dec.wren = 1'b1;
                dec.lui = 1'b1;
                dec.legal = 1'b1;
            end
            opcode_auipc: begin
                dec.imm = imm_u;
                dec.wren = 1'b1;
                dec.auipc = 1'b1;
                dec.legal = 1'b1;
            end
            opcode_jal: begin
                dec.imm = imm_j;
                dec.wren = 1'b1;
                dec.jal = 1'b1;
                dec.legal = 1'b1;
            end
            opcode_jalr: begin
                dec.imm = imm_i;
                dec.wren = 1'b1;
                dec.rden1 = 1'b1;
                dec.jalr = 1'b1;
                dec.legal = funct3 == 3'b000;
            end
            opcode_branch: begin
                dec.imm = imm_b;
                dec.rden1 = 1'b1;
                dec.rden2 = 1'b1;
                dec.branch = 1'b1;
                dec.bcu_op = funct3[2] ? bcu_op_type'({1'b0, funct3[1:0]} + 3'd2)
                                       : bcu_op_type'({2'b0, funct3[0]});
                dec.legal = funct3[2:1] != 2'b01; // funct3 2 and 3 are reserved.
            end
            opcode_load: begin
                dec.imm = imm_i;
                dec.wren = 1'b1;
                dec.rden1 = 1'b1;
                dec.load = 1'b1;
                dec.legal = (funct3[1:0] != 2'b11) && (funct3 != 3'b110);
            end
            opcode_store: begin
                dec.imm = imm_s;
                dec.rden1 = 1'b1;
                dec.rden2 = 1'b1;
                dec.store = 1'b1;
                dec.legal = (funct3[2] == 1'b0) && (funct3[1:0] != 2'b11);
            end
            opcode_opimm: begin
                dec.imm = imm_i;
                dec.wren = 1'b1;
                dec.rden1 = 1'b1;
                dec.alu_op = alu_sel(funct3, instr[30] && funct3 == 3'b101);
                if (funct3 == 3'b001) begin
                    dec.legal = funct7 == 7'b0000000;
                end else if (funct3 == 3'b101) begin
                    dec.legal = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
                end else begin
                    dec.legal = 1'b1;
                end
            end
            opcode_op: begin
                dec.wren = 1'b1;
                dec.rden1 = 1'b1;
                dec.rden2 = 1'b1;
                dec.alu_op = alu_sel(funct3, instr[30]);
                dec.legal = (funct7 == 7'b0000000) ||
                            (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
            end
            opcode_fence: begin
                dec.fence = 1'b1;
                dec.legal = funct3 == 3'b000;
            end
            opcode_system: begin
                dec.ecall = instr == 32'h00000073;
                dec.ebreak = instr == 32'h00100073;
                dec.legal = dec.ecall | dec.ebreak; // No CSR access in this core.
            end
            default: dec.legal = 1'b0;
        endcase
    end

endmodule

// File: hdl/rv_decode_pkg.sv
package rv_decode_pkg;

    localparam logic [6:0] opcode_lui    = 7'b0110111;
    localparam logic [6:0] opcode_auipc  = 7'b0010111;
    localparam logic [6:0] opcode_jal    = 7'b1101111;
    localparam logic [6:0] opcode_jalr   = 7'b1100111;
    localparam logic [6:0] opcode_branch = 7'b1100011;
    localparam logic [6:0] opcode_load   = 7'b0000011;
    localparam logic [6:0] opcode_store  = 7'b0100011;
    localparam logic [6:0] opcode_opimm  = 7'b0010011;
    localparam logic [6:0] opcode_op     = 7'b0110011;
    localparam logic [6:0] opcode_fence  = 7'b0001111;
    localparam logic [6:0] opcode_system = 7'b1110011;

    localparam logic [3:0] except_instr_misaligned    = 4'd0;
    localparam logic [3:0] except_illegal_instruction = 4'd2;
    localparam logic [3:0] except_breakpoint          = 4'd3;
    localparam logic [3:0] except_load_misaligned     = 4'd4;
    localparam logic [3:0] except_store_misaligned    = 4'd6;
    localparam logic [3:0] except_env_call_mach       = 4'd11;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
        alu_xor, alu_srl, alu_sra, alu_or, alu_and
    } alu_op_type;

    typedef enum logic [2:0] {
        bcu_beq, bcu_bne, bcu_blt, bcu_bge, bcu_bltu, bcu_bgeu
    } bcu_op_type;

    typedef struct packed {
        logic lsu_byte;
        logic lsu_half;
        logic lsu_word;
        logic lsu_unsigned;
    } lsu_op_type;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] instr;
        logic        valid;
    } fetch_type;

    typedef struct packed {
        logic        wren;
        logic [4:0]  waddr;
        logic [31:0] wdata;
    } wb_type;

    typedef struct packed {
        logic [31:0] imm;
        logic        wren;
        logic        rden1;
        logic        rden2;
        logic        auipc;
        logic        lui;
        logic        jal;
        logic        jalr;
        logic        branch;
        logic        load;
        logic        store;
        logic        ecall;
        logic        ebreak;
        logic        fence;
        alu_op_type  alu_op;
        bcu_op_type  bcu_op;
        lsu_op_type  lsu_op;
        logic        legal;
    } decoder_out_type;

    typedef struct packed {
        logic [31:0] rdata1;
        logic [31:0] imm;
        logic [31:0] pc;
        logic        jal;
        logic        jalr;
        logic        branch;
        logic        load;
        logic        store;
        lsu_op_type  lsu_op;
    } agu_in_type;

    typedef struct packed {
        logic [31:0] address;
        logic [3:0]  byteenable;
        logic        exception;
        logic [3:0]  ecause;
    } agu_out_type;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] npc;
        logic [31:0] imm;
        logic [4:0]  waddr;
        logic [4:0]  raddr1;
        logic [4:0]  raddr2;
        logic [31:0] rdata1;
        logic [31:0] rdata2;
        logic        wren;
        logic        auipc;
        logic        lui;
        logic        jal;
        logic        jalr;
        logic        branch;
        logic        load;
        logic        store;
        logic        ecall;
        logic        ebreak;
        logic        fence;
        logic        jump;
        logic [31:0] address;
        logic [3:0]  byteenable;
        alu_op_type  alu_op;
        bcu_op_type  bcu_op;
        lsu_op_type  lsu_op;
        logic        valid;
        logic        exception;
        logic [3:0]  ecause;
        logic [31:0] etval;
    } decode_out_type;

    typedef struct packed {
        logic        mem_valid;
        logic [31:0] mem_addr;
        logic [31:0] mem_wdata;
        logic [3:0]  mem_wstrb;
    } mem_req_type;

    localparam decode_out_type init_decode_out = '0;

    function automatic logic [31:0] store_data(input logic [31:0] rdata, input lsu_op_type op);
        return op.lsu_byte ? {4{rdata[7:0]}} :
               op.lsu_half ? {2{rdata[15:0]}} : rdata;
    endfunction

endpackage
